/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/Vtb_core_mem_region: compile.f *.sv *.svh
	verilator --binary --timing --assert -f compile.f --top-module tb_core_mem_region

run: obj_dir/Vtb_core_mem_region
	@out="$$(./obj_dir/Vtb_core_mem_region)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module tb_core_mem_region

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+.
mem_pkg.sv
sp_ram.sv
ram_mux.sv
lsu_demux.sv
core_mem_region.sv
core_mem_region_props.sv
tb_checker.sv
tb_core_mem_region.sv

/* core_mem_region.sv */
`timescale 1ns/10ps

module core_mem_region
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // instruction fetch
  input  logic       fetch_req_i,
  input  core_addr_t fetch_addr_i,
  output logic       fetch_gnt_o,
  output logic       fetch_rvalid_o,
  output word_t      fetch_rdata_o,

  // load/store
  input  logic       lsu_req_i,
  input  logic       lsu_we_i,
  input  core_addr_t lsu_addr_i,
  input  be_t        lsu_be_i,
  input  word_t      lsu_wdata_i,
  output logic       lsu_gnt_o,
  output logic       lsu_rvalid_o,
  output word_t      lsu_rdata_o,

  // instruction RAM loader
  input  logic       iload_req_i,
  input  logic       iload_we_i,
  input  ram_addr_t  iload_addr_i,
  input  be_t        iload_be_i,
  input  word_t      iload_wdata_i,
  output word_t      iload_rdata_o,

  // data RAM loader
  input  logic       dload_req_i,
  input  logic       dload_we_i,
  input  ram_addr_t  dload_addr_i,
  input  be_t        dload_be_i,
  input  word_t      dload_wdata_i,
  output word_t      dload_rdata_o,

  // external bus
  output logic       ext_req_o,
  output logic       ext_we_o,
  output core_addr_t ext_addr_o,
  output be_t        ext_be_o,
  output word_t      ext_wdata_o,
  input  logic       ext_gnt_i,
  input  logic       ext_rvalid_i,
  input  word_t      ext_rdata_i
);

  logic  data_req;
  logic  data_gnt;
  logic  data_rvalid;
  word_t data_rdata;

  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  lsu_demux data_demux
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ram_req_o    ( data_req     ),
    .ram_gnt_i    ( data_gnt     ),
    .ram_rvalid_i ( data_rvalid  ),
    .ram_rdata_i  ( data_rdata   ),
    .ext_req_o    ( ext_req_o    ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  )
  );

  // fetch is read only, full word
  ram_mux instr_ram_mux
  (
    .clk           ( clk            ),
    .rst_n         ( rst_n          ),
    .load_req_i    ( iload_req_i    ),
    .load_we_i     ( iload_we_i     ),
    .load_addr_i   ( iload_addr_i   ),
    .load_be_i     ( iload_be_i     ),
    .load_wdata_i  ( iload_wdata_i  ),
    .load_rdata_o  ( iload_rdata_o  ),
    .core_req_i    ( fetch_req_i    ),
    .core_we_i     ( 1'b0           ),
    .core_addr_i   ( fetch_addr_i   ),
    .core_be_i     ( '1             ),
    .core_wdata_i  ( '0             ),
    .core_gnt_o    ( fetch_gnt_o    ),
    .core_rvalid_o ( fetch_rvalid_o ),
    .core_rdata_o  ( fetch_rdata_o  )
  );

  ram_mux data_ram_mux
  (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .load_req_i    ( dload_req_i   ),
    .load_we_i     ( dload_we_i    ),
    .load_addr_i   ( dload_addr_i  ),
    .load_be_i     ( dload_be_i    ),
    .load_wdata_i  ( dload_wdata_i ),
    .load_rdata_o  ( dload_rdata_o ),
    .core_req_i    ( data_req      ),
    .core_we_i     ( lsu_we_i      ),
    .core_addr_i   ( lsu_addr_i    ),
    .core_be_i     ( lsu_be_i      ),
    .core_wdata_i  ( lsu_wdata_i   ),
    .core_gnt_o    ( data_gnt      ),
    .core_rvalid_o ( data_rvalid   ),
    .core_rdata_o  ( data_rdata    )
  );

endmodule

/* core_mem_region_props.sv */
`timescale 1ns/10ps

`include "mem_settings.svh"

module core_mem_region_props
  import mem_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       fetch_req_i,
  input logic       fetch_gnt_o,
  input logic       fetch_rvalid_o,
  input logic       lsu_req_i,
  input core_addr_t lsu_addr_i,
  input logic       lsu_gnt_o,
  input logic       lsu_rvalid_o,
  input logic       ext_req_o
);

  logic in_ram;

  assign in_ram = (lsu_addr_i[31:20] == `RAM_REGION_BASE);

  a_fetch_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_req_i && fetch_gnt_o |=> fetch_rvalid_o)
    else $error("fetch rvalid did not follow gnt by one cycle");

  a_lsu_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_req_i && lsu_gnt_o && in_ram |=> lsu_rvalid_o)
    else $error("lsu rvalid did not follow RAM gnt by one cycle");

  a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!fetch_gnt_o || fetch_req_i) && (!lsu_gnt_o || lsu_req_i))
    else $error("gnt without req");

  a_ext_region: assert property (@(posedge clk) disable iff (!rst_n)
    ext_req_o |-> !in_ram)
    else $error("external request for a RAM region address");

endmodule

bind core_mem_region core_mem_region_props u_props (.*);

/* lsu_demux.sv */
`timescale 1ns/10ps

`include "mem_settings.svh"

module lsu_demux
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       lsu_req_i,
  input  logic       lsu_we_i,
  input  core_addr_t lsu_addr_i,
  input  be_t        lsu_be_i,
  input  word_t      lsu_wdata_i,
  output logic       lsu_gnt_o,
  output logic       lsu_rvalid_o,
  output word_t      lsu_rdata_o,

  output logic       ram_req_o,
  input  logic       ram_gnt_i,
  input  logic       ram_rvalid_i,
  input  word_t      ram_rdata_i,

  output logic       ext_req_o,
  input  logic       ext_gnt_i,
  input  logic       ext_rvalid_i,
  input  word_t      ext_rdata_i
);

  localparam int REGION_BITS = 12;

  logic        is_ram;
  lsu_target_e target_q;
  lsu_target_e target_d;

  assign is_ram = (lsu_addr_i[`CORE_ADDR_WIDTH-1 -: REGION_BITS] == `RAM_REGION_BASE);

  assign ram_req_o = lsu_req_i &  is_ram;
  assign ext_req_o = lsu_req_i & ~is_ram;
  assign lsu_gnt_o = lsu_req_i & (is_ram ? ram_gnt_i : ext_gnt_i);

  // follows the region of every request, granted or not
  always_comb
  begin
    target_d = target_q;
    if (lsu_req_i)
    begin
      target_d = is_ram ? TARGET_RAM : TARGET_EXT;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      target_q <= TARGET_RAM;
    end
    else
    begin
      target_q <= target_d;
    end
  end

  // route response back to the lsu
  always_comb
  begin
    lsu_rvalid_o = ram_rvalid_i;
    lsu_rdata_o  = ram_rdata_i;
    case (target_q)
      TARGET_EXT:
      begin
        lsu_rvalid_o = ext_rvalid_i;
        lsu_rdata_o  = ext_rdata_i;
      end
      TARGET_RAM:
      begin
        lsu_rvalid_o = ram_rvalid_i;
        lsu_rdata_o  = ram_rdata_i;
      end
    endcase
  end

endmodule

/* mem_pkg.sv */
`include "mem_settings.svh"

package mem_pkg;

  typedef logic [`DATA_WIDTH-1:0]      word_t;
  typedef logic [`BE_WIDTH-1:0]        be_t;
  typedef logic [`CORE_ADDR_WIDTH-1:0] core_addr_t;
  typedef logic [`RAM_ADDR_WIDTH-1:0]  ram_addr_t;

  // where the next load/store response comes from
  typedef enum logic [0:0]
  {
    TARGET_RAM = 1'b0,
    TARGET_EXT = 1'b1
  } lsu_target_e;

endpackage

/* mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// word address width of each RAM, 4096 words
`define RAM_ADDR_WIDTH 12

`define DATA_WIDTH 32
`define BE_WIDTH 4

// byte address width seen by the core ports
`define CORE_ADDR_WIDTH 32

// top 12 address bits that select the data RAM
`define RAM_REGION_BASE 12'h001

`endif

/* ram_mux.sv */
`timescale 1ns/10ps

`include "mem_settings.svh"

module ram_mux
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // loader port, always wins
  input  logic       load_req_i,
  input  logic       load_we_i,
  input  ram_addr_t  load_addr_i,
  input  be_t        load_be_i,
  input  word_t      load_wdata_i,
  output word_t      load_rdata_o,

  // core port
  input  logic       core_req_i,
  input  logic       core_we_i,
  input  core_addr_t core_addr_i,
  input  be_t        core_be_i,
  input  word_t      core_wdata_i,
  output logic       core_gnt_o,
  output logic       core_rvalid_o,
  output word_t      core_rdata_o
);

  logic      ram_en;
  logic      ram_we;
  ram_addr_t ram_addr;
  be_t       ram_be;
  word_t     ram_wdata;
  word_t     ram_rdata;

  logic      core_rvalid_q;

  assign core_gnt_o = core_req_i & ~load_req_i;

  always_comb
  begin
    ram_en = load_req_i | core_req_i;
    if (load_req_i)
    begin
      ram_we    = load_we_i;
      ram_addr  = load_addr_i;
      ram_be    = load_be_i;
      ram_wdata = load_wdata_i;
    end
    else
    begin
      ram_we    = core_we_i;
      // byte address to word address
      ram_addr  = core_addr_i[`RAM_ADDR_WIDTH+1:2];
      ram_be    = core_be_i;
      ram_wdata = core_wdata_i;
    end
  end

  // response for a granted core access arrives one cycle later
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      core_rvalid_q <= 1'b0;
    end
    else
    begin
      core_rvalid_q <= core_gnt_o;
    end
  end

  assign core_rvalid_o = core_rvalid_q;
  assign core_rdata_o  = ram_rdata;
  assign load_rdata_o  = ram_rdata;

  sp_ram ram_i
  (
    .clk     ( clk       ),
    .en_i    ( ram_en    ),
    .we_i    ( ram_we    ),
    .addr_i  ( ram_addr  ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

endmodule

/* sp_ram.sv */
`timescale 1ns/10ps

`include "mem_settings.svh"

module sp_ram
  import mem_pkg::*;
(
  input  logic      clk,

  input  logic      en_i,
  input  logic      we_i,
  input  ram_addr_t addr_i,
  input  be_t       be_i,
  input  word_t     wdata_i,
  output word_t     rdata_o
);

  localparam int NUM_WORDS = 2 ** `RAM_ADDR_WIDTH;

  word_t mem [NUM_WORDS];

  // byte lane writes
  always_ff @(posedge clk)
  begin
    if (en_i && we_i)
    begin
      for (int i = 0; i < `BE_WIDTH; i++)
      begin
        if (be_i[i])
        begin
          mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // registered read, old contents on a write cycle
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

/* tb_checker.sv */
`timescale 1ns/10ps

`include "mem_settings.svh"

module tb_checker
  import mem_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       fetch_req_i,
  input core_addr_t fetch_addr_i,
  input logic       fetch_gnt_o,
  input logic       fetch_rvalid_o,
  input word_t      fetch_rdata_o,
  input logic       lsu_req_i,
  input logic       lsu_we_i,
  input core_addr_t lsu_addr_i,
  input be_t        lsu_be_i,
  input word_t      lsu_wdata_i,
  input logic       lsu_gnt_o,
  input logic       lsu_rvalid_o,
  input word_t      lsu_rdata_o,
  input logic       iload_req_i,
  input logic       iload_we_i,
  input ram_addr_t  iload_addr_i,
  input be_t        iload_be_i,
  input word_t      iload_wdata_i,
  input word_t      iload_rdata_o,
  input logic       dload_req_i,
  input logic       dload_we_i,
  input ram_addr_t  dload_addr_i,
  input be_t        dload_be_i,
  input word_t      dload_wdata_i,
  input word_t      dload_rdata_o,
  input logic       ext_req_o,
  input logic       ext_we_o,
  input core_addr_t ext_addr_o,
  input be_t        ext_be_o,
  input word_t      ext_wdata_o
);

  // reference images of both RAMs
  word_t imem [2 ** `RAM_ADDR_WIDTH];
  word_t dmem [2 ** `RAM_ADDR_WIDTH];

  word_t fetch_q [$];
  word_t lsu_q [$];
  bit    lsu_rd_q [$];

  logic  iload_pend = 1'b0;
  logic  dload_pend = 1'b0;
  word_t iload_exp;
  word_t dload_exp;
  bit    lsu_rd;
  word_t lsu_exp;

  int    err_count = 0;
  int    check_count = 0;
  string cur_test = "reset";

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
    word_t res;
    res = old_w;
    for (int i = 0; i < `BE_WIDTH; i++)
    begin
      if (be[i])
      begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic compare(input string what, input word_t exp, input word_t act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("Fail %s (%s) expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      if (fetch_rvalid_o || lsu_rvalid_o || ext_req_o)
      begin
        err_count++;
        $display("response valid or external request seen while in reset");
      end
    end
    else
    begin
      // responses to requests accepted at earlier edges
      if (fetch_rvalid_o)
      begin
        if (fetch_q.size() == 0)
        begin
          err_count++;
          $display("%s: fetch rvalid without an accepted request", cur_test);
        end
        else
        begin
          compare("fetch", fetch_q.pop_front(), fetch_rdata_o);
        end
      end
      if (lsu_rvalid_o)
      begin
        if (lsu_q.size() == 0)
        begin
          err_count++;
          $display("%s: lsu rvalid without an accepted request", cur_test);
        end
        else
        begin
          lsu_exp = lsu_q.pop_front();
          lsu_rd  = lsu_rd_q.pop_front();
          if (lsu_rd)
          begin
            compare("lsu", lsu_exp, lsu_rdata_o);
          end
        end
      end
      if (iload_pend)
      begin
        compare("iload", iload_exp, iload_rdata_o);
      end
      if (dload_pend)
      begin
        compare("dload", dload_exp, dload_rdata_o);
      end
      iload_pend = 1'b0;
      dload_pend = 1'b0;

      // external port carries exactly the load/stores outside the RAM region
      if (lsu_req_i && lsu_addr_i[31:20] != `RAM_REGION_BASE)
      begin
        compare("ext_req", word_t'(1), word_t'(ext_req_o));
        compare("ext_addr", lsu_addr_i, ext_addr_o);
        compare("ext_we", word_t'(lsu_we_i), word_t'(ext_we_o));
        compare("ext_be", word_t'(lsu_be_i), word_t'(ext_be_o));
        compare("ext_wdata", lsu_wdata_i, ext_wdata_o);
      end
      else
      begin
        compare("ext_req", word_t'(0), word_t'(ext_req_o));
      end

      // new requests at this edge
      if (iload_req_i)
      begin
        if (iload_we_i)
        begin
          imem[iload_addr_i] = merge_bytes(imem[iload_addr_i], iload_wdata_i, iload_be_i);
        end
        else
        begin
          iload_pend = 1'b1;
          iload_exp  = imem[iload_addr_i];
        end
      end
      if (dload_req_i)
      begin
        if (dload_we_i)
        begin
          dmem[dload_addr_i] = merge_bytes(dmem[dload_addr_i], dload_wdata_i, dload_be_i);
        end
        else
        begin
          dload_pend = 1'b1;
          dload_exp  = dmem[dload_addr_i];
        end
      end
      if (fetch_req_i && fetch_gnt_o)
      begin
        fetch_q.push_back(imem[fetch_addr_i[`RAM_ADDR_WIDTH+1:2]]);
      end
      if (lsu_req_i && lsu_gnt_o)
      begin
        lsu_rd_q.push_back(!lsu_we_i);
        if (lsu_addr_i[31:20] == `RAM_REGION_BASE)
        begin
          if (lsu_we_i)
          begin
            dmem[lsu_addr_i[`RAM_ADDR_WIDTH+1:2]] =
              merge_bytes(dmem[lsu_addr_i[`RAM_ADDR_WIDTH+1:2]], lsu_wdata_i, lsu_be_i);
          end
          lsu_q.push_back(dmem[lsu_addr_i[`RAM_ADDR_WIDTH+1:2]]);
        end
        else
        begin
          // responder echoes the address scrambled
          lsu_q.push_back(lsu_addr_i ^ 32'h5a5a0000);
        end
      end
    end
  end

endmodule

/* tb_core_mem_region.sv */
`timescale 1ns/10ps

`include "mem_settings.svh"

module tb_core_mem_region;
  import mem_pkg::*;

  localparam int P_FETCH = 0;
  localparam int P_LSU   = 1;
  localparam int P_ILOAD = 2;
  localparam int P_DLOAD = 3;
  localparam int OP_RD   = 0;
  localparam int OP_WR   = 1;
  localparam int WAIT_MAX = 20;

  logic       clk;
  logic       rst_n;
  logic       fetch_req_i;
  core_addr_t fetch_addr_i;
  logic       fetch_gnt_o;
  logic       fetch_rvalid_o;
  word_t      fetch_rdata_o;
  logic       lsu_req_i;
  logic       lsu_we_i;
  core_addr_t lsu_addr_i;
  be_t        lsu_be_i;
  word_t      lsu_wdata_i;
  logic       lsu_gnt_o;
  logic       lsu_rvalid_o;
  word_t      lsu_rdata_o;
  logic       iload_req_i;
  logic       iload_we_i;
  ram_addr_t  iload_addr_i;
  be_t        iload_be_i;
  word_t      iload_wdata_i;
  word_t      iload_rdata_o;
  logic       dload_req_i;
  logic       dload_we_i;
  ram_addr_t  dload_addr_i;
  be_t        dload_be_i;
  word_t      dload_wdata_i;
  word_t      dload_rdata_o;
  logic       ext_req_o;
  logic       ext_we_o;
  core_addr_t ext_addr_o;
  be_t        ext_be_o;
  word_t      ext_wdata_o;
  logic       ext_gnt_i;
  logic       ext_rvalid_i;
  word_t      ext_rdata_i;

  // stimulus table
  string      t_name [$];
  int         t_port [$];
  int         t_op [$];
  core_addr_t t_addr [$];
  be_t        t_be [$];
  word_t      t_data [$];
  bit         t_ld [$];

  int         tb_errors = 0;
  int         seed = 32'h515e779f;
  int         ext_cnt;
  core_addr_t ext_addr_q;

  core_mem_region u_dut (.*);

  tb_checker u_checker (.*);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;
    end
  end

  // external bus responder, 1 to 3 cycles of latency
  always @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ext_rvalid_i <= 1'b0;
      ext_rdata_i  <= '0;
      ext_cnt      <= 0;
      ext_addr_q   <= '0;
    end
    else
    begin
      ext_rvalid_i <= 1'b0;
      if (ext_cnt != 0)
      begin
        ext_cnt <= ext_cnt - 1;
        if (ext_cnt == 1)
        begin
          ext_rvalid_i <= 1'b1;
          ext_rdata_i  <= ext_addr_q ^ 32'h5a5a0000;
        end
      end
      else if (ext_req_o && ext_gnt_i)
      begin
        ext_addr_q <= ext_addr_o;
        ext_cnt    <= 1 + int'($unsigned($random(seed)) % 3);
      end
    end
  end

  task automatic add_entry(input string name, input int port, input int op,
                           input core_addr_t addr, input be_t be, input word_t data,
                           input bit ld);
    t_name.push_back(name);
    t_port.push_back(port);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_be.push_back(be);
    t_data.push_back(data);
    t_ld.push_back(ld);
  endtask

  task automatic run_entry(input int i);
    int  n;
    bit  gnt;
    bit  rv;
    bit  ram_target;
    ram_target = (t_port[i] == P_FETCH) || (t_addr[i][31:20] == `RAM_REGION_BASE);
    u_checker.cur_test <= t_name[i];
    @(posedge clk);
    case (t_port[i])
      P_FETCH:
      begin
        fetch_req_i  <= 1'b1;
        fetch_addr_i <= t_addr[i];
      end
      P_LSU:
      begin
        lsu_req_i   <= 1'b1;
        lsu_we_i    <= (t_op[i] == OP_WR);
        lsu_addr_i  <= t_addr[i];
        lsu_be_i    <= t_be[i];
        lsu_wdata_i <= t_data[i];
      end
      P_ILOAD:
      begin
        iload_req_i   <= 1'b1;
        iload_we_i    <= (t_op[i] == OP_WR);
        iload_addr_i  <= t_addr[i][`RAM_ADDR_WIDTH-1:0];
        iload_be_i    <= t_be[i];
        iload_wdata_i <= t_data[i];
      end
      default:
      begin
        dload_req_i   <= 1'b1;
        dload_we_i    <= (t_op[i] == OP_WR);
        dload_addr_i  <= t_addr[i][`RAM_ADDR_WIDTH-1:0];
        dload_be_i    <= t_be[i];
        dload_wdata_i <= t_data[i];
      end
    endcase
    // competing loader write to the next word
    if (t_ld[i] && t_port[i] == P_FETCH)
    begin
      iload_req_i   <= 1'b1;
      iload_we_i    <= 1'b1;
      iload_addr_i  <= t_addr[i][`RAM_ADDR_WIDTH+1:2] + ram_addr_t'(1);
      iload_be_i    <= '1;
      iload_wdata_i <= ~t_data[i];
    end
    if (t_ld[i] && t_port[i] == P_LSU)
    begin
      dload_req_i   <= 1'b1;
      dload_we_i    <= 1'b1;
      dload_addr_i  <= t_addr[i][`RAM_ADDR_WIDTH+1:2] + ram_addr_t'(1);
      dload_be_i    <= '1;
      dload_wdata_i <= ~t_data[i];
    end
    if (t_port[i] >= P_ILOAD)
    begin
      @(posedge clk);
      iload_req_i <= 1'b0;
      dload_req_i <= 1'b0;
      @(posedge clk);
      return;
    end
    n   = 0;
    gnt = 1'b0;
    while (!gnt && n < WAIT_MAX)
    begin
      @(posedge clk);
      gnt = (t_port[i] == P_FETCH) ? fetch_gnt_o : lsu_gnt_o;
      if (n == 0 && t_ld[i] && gnt)
      begin
        tb_errors++;
        $display("Fail %s expected gnt 0 actual 1", t_name[i]);
      end
      else if (n == 0 && !t_ld[i] && !gnt)
      begin
        tb_errors++;
        $display("Fail %s expected gnt 1 actual 0", t_name[i]);
      end
      iload_req_i <= 1'b0;
      dload_req_i <= 1'b0;
      n++;
    end
    fetch_req_i <= 1'b0;
    lsu_req_i   <= 1'b0;
    if (!gnt)
    begin
      tb_errors++;
      $display("%s: timed out waiting for gnt", t_name[i]);
      return;
    end
    n  = 0;
    rv = 1'b0;
    while (!rv && n < WAIT_MAX)
    begin
      @(posedge clk);
      rv = (t_port[i] == P_FETCH) ? fetch_rvalid_o : lsu_rvalid_o;
      // RAM responses come exactly one cycle after gnt
      if (n == 0 && ram_target && !rv)
      begin
        tb_errors++;
        $display("Fail %s expected rvalid 1 actual 0", t_name[i]);
      end
      n++;
    end
    if (!rv)
    begin
      tb_errors++;
      $display("%s: timed out waiting for rvalid", t_name[i]);
    end
  endtask

  initial
  begin
    #20000;
    $display("global timeout, the run did not finish");
    $display("sim failed");
    $finish;
  end

  initial
  begin
    rst_n        = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    lsu_req_i    = 1'b0;
    lsu_we_i     = 1'b0;
    lsu_addr_i   = '0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    iload_req_i  = 1'b0;
    iload_we_i   = 1'b0;
    iload_addr_i = '0;
    iload_be_i   = '0;
    iload_wdata_i = '0;
    dload_req_i  = 1'b0;
    dload_we_i   = 1'b0;
    dload_addr_i = '0;
    dload_be_i   = '0;
    dload_wdata_i = '0;
    ext_gnt_i    = 1'b1;

    add_entry("lsu_wr_full", P_LSU, OP_WR, 32'h0010_0010, 4'hf, 32'ha1b2c3d4, 0);
    add_entry("lsu_wr_bytes", P_LSU, OP_WR, 32'h0010_0010, 4'b0101, 32'h00ee00ff, 0);
    add_entry("lsu_rd_merge", P_LSU, OP_RD, 32'h0010_0010, 4'hf, 32'h0, 0);
    add_entry("lsu_wr_word5", P_LSU, OP_WR, 32'h0010_0014, 4'hf, 32'h01020304, 0);
    add_entry("lsu_wr_upper", P_LSU, OP_WR, 32'h0010_0014, 4'b1100, 32'hbbaa0000, 0);
    add_entry("lsu_rd_upper", P_LSU, OP_RD, 32'h0010_0014, 4'hf, 32'h0, 0);
    add_entry("iload_wr_8", P_ILOAD, OP_WR, 32'h8, 4'hf, 32'hcafe0001, 0);
    add_entry("iload_wr_9", P_ILOAD, OP_WR, 32'h9, 4'hf, 32'hcafe0002, 0);
    add_entry("fetch_rd_8", P_FETCH, OP_RD, 32'h0000_0020, 4'hf, 32'h0, 0);
    add_entry("fetch_rd_9", P_FETCH, OP_RD, 32'h0000_0024, 4'hf, 32'h0, 0);
    add_entry("ext_wr", P_LSU, OP_WR, 32'h2000_0014, 4'hf, 32'hdeadbeef, 0);
    add_entry("ext_rd", P_LSU, OP_RD, 32'h2000_0014, 4'hf, 32'h0, 0);
    add_entry("ext_rd_hi", P_LSU, OP_RD, 32'hfff0_0100, 4'hf, 32'h0, 0);
    add_entry("ram_untouched", P_LSU, OP_RD, 32'h0010_0014, 4'hf, 32'h0, 0);
    add_entry("fetch_conflict", P_FETCH, OP_RD, 32'h0000_0020, 4'hf, 32'h12345678, 1);
    add_entry("fetch_after_ld", P_FETCH, OP_RD, 32'h0000_0024, 4'hf, 32'h0, 0);
    add_entry("lsu_conflict", P_LSU, OP_WR, 32'h0010_0010, 4'hf, 32'h55aa33cc, 1);
    add_entry("lsu_after_ld", P_LSU, OP_RD, 32'h0010_0014, 4'hf, 32'h0, 0);
    add_entry("dload_rd_4", P_DLOAD, OP_RD, 32'h4, 4'hf, 32'h0, 0);
    add_entry("dload_rd_5", P_DLOAD, OP_RD, 32'h5, 4'hf, 32'h0, 0);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    for (int i = 0; i < t_name.size(); i++)
    begin
      run_entry(i);
    end
    repeat (4) @(posedge clk);

    $display("checks %0d, checker errors %0d, sequence errors %0d",
             u_checker.check_count, u_checker.err_count, tb_errors);
    if (u_checker.err_count == 0 && tb_errors == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
